// File: spi_pkg.sv
// --------------------------------------------------
// SPI master shared definitions
// --------------------------------------------------

package spi_pkg;

    // Word and bus sizes
    localparam int DATA_WIDTH = 8;
    localparam int SLAVE_NUM  = 4;
    localparam int ADDR_WIDTH = 2;

    // Configuration input widths
    localparam int DIV_WIDTH  = 16;
    localparam int WAIT_WIDTH = 16;

    // Entries in each stream queue
    localparam int FIFO_DEPTH = 4;

    // SCK edges per word and the counter that tracks them
    localparam int EDGE_NUM       = 2 * DATA_WIDTH;
    localparam int EDGE_CNT_WIDTH = $clog2(EDGE_NUM);

    // --------------------------------------------------
    // Stream payloads
    // --------------------------------------------------

    // Byte headed for MOSI
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } tx_beat_t;

    // Byte taken from MISO, tagged with its frame position and target
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        logic [ADDR_WIDTH-1:0] addr;
    } rx_beat_t;

endpackage

// File: stream_fifo.sv
// --------------------------------------------------
// Valid/ready stream queue
// --------------------------------------------------

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,

    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] count_next;
    logic                 in_ready_q;
    logic                 out_valid_q;
    logic                 push;
    logic                 pop;

    assign push = in_valid_i && in_ready_q;
    assign pop  = out_valid_q && out_ready_i;

    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // --------------------------------------------------
    // Pointers, occupancy and handshake flags
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            in_ready_q  <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            count       <= count_next;
            // Flags follow the occupancy of the next cycle
            in_ready_q  <= (count_next != CNT_WIDTH'(DEPTH));
            out_valid_q <= (count_next != '0);
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    assign in_ready_o  = in_ready_q;
    assign out_valid_o = out_valid_q;
    // Head entry shows through as soon as it is written
    assign out_data_o  = mem[rd_ptr];

endmodule

// File: spi_clk_gen.sv
// --------------------------------------------------
// SPI clock and edge strobes
// --------------------------------------------------

module spi_clk_gen (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          cpol_i,
    input  logic [spi_pkg::DIV_WIDTH-1:0] clk_div_i,
    input  logic                          frame_active_i,
    output logic                          sck_o,
    output logic                          lead_stb_o,
    output logic                          trail_stb_o,
    output logic                          byte_done_o
);

    logic [spi_pkg::DIV_WIDTH-1:0]      clk_cnt;
    logic [spi_pkg::EDGE_CNT_WIDTH-1:0] edge_cnt;
    logic                               sck_q;
    logic                               finished;
    logic                               run;
    logic                               half_hit;
    logic                               full_hit;
    logic                               last_edge;

    // Stop after the final edge until the engine drops the frame
    assign run = frame_active_i && !finished;

    // Half point gives the leading edge, end of period the trailing one
    assign half_hit  = run && (clk_cnt == (clk_div_i >> 1) - 1'b1);
    assign full_hit  = run && (clk_cnt == clk_div_i - 1'b1);
    assign last_edge = (edge_cnt == spi_pkg::EDGE_CNT_WIDTH'(spi_pkg::EDGE_NUM - 1));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            clk_cnt     <= '0;
            edge_cnt    <= '0;
            finished    <= 1'b0;
            sck_q       <= cpol_i;
            lead_stb_o  <= 1'b0;
            trail_stb_o <= 1'b0;
            byte_done_o <= 1'b0;
        end else begin
            // Strobes line up with the new SCK level
            lead_stb_o  <= half_hit;
            trail_stb_o <= full_hit;
            byte_done_o <= 1'b0;

            if (!frame_active_i) begin
                clk_cnt  <= '0;
                edge_cnt <= '0;
                finished <= 1'b0;
                sck_q    <= cpol_i;
            end else if (run) begin
                if (full_hit) begin
                    clk_cnt <= '0;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end

                if (half_hit || full_hit) begin
                    sck_q    <= ~sck_q;
                    edge_cnt <= edge_cnt + 1'b1;
                end

                // Last trailing edge closes the word
                if (full_hit && last_edge) begin
                    edge_cnt    <= '0;
                    finished    <= 1'b1;
                    byte_done_o <= 1'b1;
                end
            end
        end
    end

    assign sck_o = sck_q;

endmodule

// File: spi_shift_engine.sv
// --------------------------------------------------
// SPI frame FSM and shift registers
// --------------------------------------------------

module spi_shift_engine (
    input  logic                           clk_i,
    input  logic                           rstn_i,

    // Static configuration
    input  logic                           cpha_i,
    input  logic [spi_pkg::WAIT_WIDTH-1:0] wait_time_i,
    input  logic [spi_pkg::ADDR_WIDTH-1:0] addr_i,

    // Transmit queue side
    input  logic                           tx_valid_i,
    input  spi_pkg::tx_beat_t              tx_data_i,
    output logic                           tx_ready_o,

    // Receive queue has a free slot
    input  logic                           rx_space_i,

    // Clock generator
    input  logic                           lead_stb_i,
    input  logic                           trail_stb_i,
    input  logic                           byte_done_i,
    output logic                           frame_active_o,

    // SPI pins
    output logic                           mosi_o,
    input  logic                           miso_i,
    output logic [spi_pkg::SLAVE_NUM-1:0]  cs_n_o,

    // Receive push
    output logic                           rx_push_o,
    output spi_pkg::rx_beat_t              rx_data_o
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        DATA = 2'b01,
        WAIT = 2'b10
    } state_e;

    state_e                         state;
    logic [spi_pkg::WAIT_WIDTH-1:0] wait_cnt;
    logic                           wait_done;
    logic                           cs_active;
    logic                           rx_push_q;
    logic                           mosi_q;
    logic [spi_pkg::DATA_WIDTH-1:0] tx_shift;
    logic [spi_pkg::DATA_WIDTH-1:0] rx_shift;
    logic                           last_q;
    logic [spi_pkg::ADDR_WIDTH-1:0] addr_q;
    logic                           accept;
    logic                           shift_evt;
    logic                           sample_evt;

    // Hold off input while a push is still on its way to the receive queue
    assign tx_ready_o = (state == IDLE) && rx_space_i && !rx_push_q;
    assign accept     = tx_valid_i && tx_ready_o;

    // CPHA picks which edge drives and which one samples
    assign shift_evt  = cpha_i ? lead_stb_i : trail_stb_i;
    assign sample_evt = cpha_i ? trail_stb_i : lead_stb_i;

    assign wait_done  = ((wait_cnt + 1'b1) >= wait_time_i);

    // --------------------------------------------------
    // Frame state machine
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= IDLE;
            cs_active <= 1'b0;
            wait_cnt  <= '0;
            rx_push_q <= 1'b0;
        end else begin
            rx_push_q <= byte_done_i && (state == DATA);
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= DATA;
                        cs_active <= 1'b1;
                    end
                end
                DATA: begin
                    if (byte_done_i) begin
                        if (last_q) begin
                            // End of frame, release every select line
                            state     <= WAIT;
                            cs_active <= 1'b0;
                            wait_cnt  <= '0;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                WAIT: begin
                    if (wait_done) begin
                        state    <= IDLE;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign frame_active_o = (state == DATA);

    // --------------------------------------------------
    // MOSI
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mosi_q <= 1'b0;
        end else if (accept && !cpha_i) begin
            // First bit set up before the first leading edge
            mosi_q <= tx_data_i.data[spi_pkg::DATA_WIDTH-1];
        end else if ((state == DATA) && shift_evt) begin
            mosi_q <= tx_shift[spi_pkg::DATA_WIDTH-1];
        end
    end

    assign mosi_o = mosi_q;

    // Word payload latched at accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            last_q <= tx_data_i.last;
            addr_q <= addr_i;
            if (cpha_i) begin
                tx_shift <= tx_data_i.data;
            end else begin
                tx_shift <= tx_data_i.data << 1;
            end
        end else if ((state == DATA) && shift_evt) begin
            tx_shift <= tx_shift << 1;
        end
    end

    // --------------------------------------------------
    // MISO, MSB first
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if ((state == DATA) && sample_evt) begin
            rx_shift <= {rx_shift[spi_pkg::DATA_WIDTH-2:0], miso_i};
        end
    end

    // One select line low, the addressed one
    always_comb begin
        for (int i = 0; i < spi_pkg::SLAVE_NUM; i++) begin
            cs_n_o[i] = !(cs_active && (addr_q == spi_pkg::ADDR_WIDTH'(i)));
        end
    end

    assign rx_push_o      = rx_push_q;
    assign rx_data_o.data = rx_shift;
    assign rx_data_o.last = last_q;
    assign rx_data_o.addr = addr_q;

endmodule

// File: spi_master_top.sv
// --------------------------------------------------
// SPI master with byte streams
// --------------------------------------------------

module spi_master_top (
    input  logic                           clk_i,
    input  logic                           rstn_i,

    // Static configuration
    input  logic                           cpol_i,
    input  logic                           cpha_i,
    input  logic [spi_pkg::DIV_WIDTH-1:0]  clk_div_i,
    input  logic [spi_pkg::WAIT_WIDTH-1:0] wait_time_i,
    input  logic [spi_pkg::ADDR_WIDTH-1:0] addr_i,

    // Input byte stream
    input  logic                           s_valid_i,
    input  logic [spi_pkg::DATA_WIDTH-1:0] s_data_i,
    input  logic                           s_last_i,
    output logic                           s_ready_o,

    // Received byte stream
    output logic                           m_valid_o,
    output logic [spi_pkg::DATA_WIDTH-1:0] m_data_o,
    output logic                           m_last_o,
    output logic [spi_pkg::ADDR_WIDTH-1:0] m_addr_o,
    input  logic                           m_ready_i,

    // SPI pins
    output logic                           sck_o,
    output logic                           mosi_o,
    output logic [spi_pkg::SLAVE_NUM-1:0]  cs_n_o,
    input  logic                           miso_i
);

    spi_pkg::tx_beat_t s_beat;
    spi_pkg::tx_beat_t tx_beat;
    spi_pkg::rx_beat_t rx_beat;
    spi_pkg::rx_beat_t m_beat;
    logic              tx_valid;
    logic              tx_ready;
    logic              rx_push;
    logic              rx_space;
    logic              frame_active;
    logic              lead_stb;
    logic              trail_stb;
    logic              byte_done;

    assign s_beat.data = s_data_i;
    assign s_beat.last = s_last_i;

    // --------------------------------------------------
    // Transmit queue
    // --------------------------------------------------
    stream_fifo #(
        .payload_t (spi_pkg::tx_beat_t),
        .DEPTH     (spi_pkg::FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (s_valid_i),
        .in_data_i   (s_beat),
        .in_ready_o  (s_ready_o),
        .out_valid_o (tx_valid),
        .out_data_o  (tx_beat),
        .out_ready_i (tx_ready)
    );

    spi_clk_gen u_spi_clk_gen (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cpol_i         (cpol_i),
        .clk_div_i      (clk_div_i),
        .frame_active_i (frame_active),
        .sck_o          (sck_o),
        .lead_stb_o     (lead_stb),
        .trail_stb_o    (trail_stb),
        .byte_done_o    (byte_done)
    );

    spi_shift_engine u_spi_shift_engine (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cpha_i         (cpha_i),
        .wait_time_i    (wait_time_i),
        .addr_i         (addr_i),
        .tx_valid_i     (tx_valid),
        .tx_data_i      (tx_beat),
        .tx_ready_o     (tx_ready),
        .rx_space_i     (rx_space),
        .lead_stb_i     (lead_stb),
        .trail_stb_i    (trail_stb),
        .byte_done_i    (byte_done),
        .frame_active_o (frame_active),
        .mosi_o         (mosi_o),
        .miso_i         (miso_i),
        .cs_n_o         (cs_n_o),
        .rx_push_o      (rx_push),
        .rx_data_o      (rx_beat)
    );

    // --------------------------------------------------
    // Receive queue, its input ready doubles as free space
    // --------------------------------------------------
    stream_fifo #(
        .payload_t (spi_pkg::rx_beat_t),
        .DEPTH     (spi_pkg::FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (rx_push),
        .in_data_i   (rx_beat),
        .in_ready_o  (rx_space),
        .out_valid_o (m_valid_o),
        .out_data_o  (m_beat),
        .out_ready_i (m_ready_i)
    );

    assign m_data_o = m_beat.data;
    assign m_last_o = m_beat.last;
    assign m_addr_o = m_beat.addr;

endmodule

// File: spi_master_sva.sv
// --------------------------------------------------
// SPI master protocol assertions
// --------------------------------------------------

module spi_master_sva (
    input logic                           clk_i,
    input logic                           rstn_i,
    input logic                           cpol_i,
    input logic [spi_pkg::ADDR_WIDTH-1:0] addr_i,
    input logic                           sck_i,
    input logic [spi_pkg::SLAVE_NUM-1:0]  cs_n_i,
    input logic                           m_valid_i,
    input logic [spi_pkg::DATA_WIDTH-1:0] m_data_i,
    input logic                           m_last_i,
    input logic [spi_pkg::ADDR_WIDTH-1:0] m_addr_i,
    input logic                           m_ready_i
);

    // Running count of failed assertions
    int unsigned fail_cnt = 0;

    // Only the addressed slave is ever selected
    a_cs_addr: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(&cs_n_i) |-> ((~cs_n_i) == (spi_pkg::SLAVE_NUM'(1) << addr_i))
    ) else begin
        fail_cnt++;
        $error("A chip select line other than the addressed one is low");
    end

    // SCK rests at CPOL outside frames
    // One cycle of slack after a CPOL change
    a_sck_idle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ((&cs_n_i) && $stable(cpol_i)) |-> (sck_i == cpol_i)
    ) else begin
        fail_cnt++;
        $error("SCK left its idle level while every chip select line is high");
    end

    // Stalled output beat holds still
    a_out_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable({m_data_i, m_last_i, m_addr_i}))
    ) else begin
        fail_cnt++;
        $error("Output stream changed while the consumer was not ready");
    end

endmodule

// File: tb_spi_master.sv
// --------------------------------------------------
// SPI master loopback testbench
// --------------------------------------------------

module tb_spi_master;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int TOTAL_BYTES  = 40;
    localparam int MAX_DIV      = 10;
    localparam int MAX_WAIT     = 25;
    localparam int TIMEOUT_CYCLES =
        TOTAL_BYTES * (MAX_DIV * spi_pkg::DATA_WIDTH + MAX_WAIT + 20) + 2000;

    // Beats held by a full transmit queue and a full receive queue
    localparam int STALL_BEATS = 2 * spi_pkg::FIFO_DEPTH;
    localparam int STALL_LIMIT = 400;
    localparam int STALL_HOLD  = 4 * MAX_DIV * spi_pkg::DATA_WIDTH;

    logic                           clk_i;
    logic                           rstn_i;
    logic                           cpol_i;
    logic                           cpha_i;
    logic [spi_pkg::DIV_WIDTH-1:0]  clk_div_i;
    logic [spi_pkg::WAIT_WIDTH-1:0] wait_time_i;
    logic [spi_pkg::ADDR_WIDTH-1:0] addr_i;
    logic                           s_valid_i;
    logic [spi_pkg::DATA_WIDTH-1:0] s_data_i;
    logic                           s_last_i;
    logic                           s_ready_o;
    logic                           m_valid_o;
    logic [spi_pkg::DATA_WIDTH-1:0] m_data_o;
    logic                           m_last_o;
    logic [spi_pkg::ADDR_WIDTH-1:0] m_addr_o;
    logic                           m_ready_i;
    logic                           sck_o;
    logic                           mosi_o;
    logic [spi_pkg::SLAVE_NUM-1:0]  cs_n_o;
    logic                           miso_i;

    string             test_name;
    spi_pkg::rx_beat_t expect_q[$];
    spi_pkg::rx_beat_t exp_beat;
    int unsigned       cycle_cnt = 0;
    int unsigned       gap_cnt = 0;
    int unsigned       gap_need = 0;
    int unsigned       gap_checks = 0;
    int unsigned       checks_before;
    int unsigned       stall_cycles;
    int unsigned       held_beats;
    logic              saw_ready_drop;

    // Slave side is a plain wire back to the master
    assign miso_i = mosi_o;

    spi_master_top u_spi_master_top (.*);

    bind spi_master_top spi_master_sva u_spi_master_sva (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .cpol_i    (cpol_i),
        .addr_i    (addr_i),
        .sck_i     (sck_o),
        .cs_n_i    (cs_n_o),
        .m_valid_i (m_valid_o),
        .m_data_i  (m_data_o),
        .m_last_i  (m_last_o),
        .m_addr_i  (m_addr_o),
        .m_ready_i (m_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string field, input int exp_val, input int act_val);
        abort_run($sformatf("ERROR %s: %s expected 0x%0h actual 0x%0h",
                            test_name, field, exp_val, act_val));
    endtask

    // Starts and ends on a falling edge
    task automatic send_byte(input logic [spi_pkg::DATA_WIDTH-1:0] data, input logic last);
        spi_pkg::rx_beat_t beat;
        s_valid_i = 1'b1;
        s_data_i  = data;
        s_last_i  = last;
        @(posedge clk_i);
        while (!s_ready_o) begin
            @(posedge clk_i);
        end
        // Loopback returns the byte tagged with the current target
        beat.data = data;
        beat.last = last;
        beat.addr = addr_i;
        expect_q.push_back(beat);
        @(negedge clk_i);
        s_valid_i = 1'b0;
    endtask

    task automatic send_frame(input int len);
        logic [spi_pkg::DATA_WIDTH-1:0] data;
        for (int i = 0; i < len; i++) begin
            data = spi_pkg::DATA_WIDTH'($urandom_range((1 << spi_pkg::DATA_WIDTH) - 1));
            send_byte(data, i == len - 1);
        end
    endtask

    task automatic set_config(input logic cpol, input logic cpha, input int div,
                              input int gap, input int addr);
        cpol_i      = cpol;
        cpha_i      = cpha;
        clk_div_i   = spi_pkg::DIV_WIDTH'(div);
        wait_time_i = spi_pkg::WAIT_WIDTH'(gap);
        addr_i      = spi_pkg::ADDR_WIDTH'(addr);
        repeat (2) @(negedge clk_i);
    endtask

    // All beats back and the inter-frame gap over
    task automatic wait_idle();
        while (expect_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (wait_time_i + 4) @(posedge clk_i);
        @(negedge clk_i);
    endtask

    // --------------------------------------------------
    // Monitors
    // --------------------------------------------------
    always @(posedge clk_i) begin
        if (rstn_i && m_valid_o && m_ready_i) begin
            if (expect_q.size() == 0) begin
                abort_run("An output beat arrived while no byte was outstanding");
            end else begin
                exp_beat = expect_q.pop_front();
                assert (m_data_o == exp_beat.data)
                    else report_value("m_data_o", exp_beat.data, m_data_o);
                assert (m_last_o == exp_beat.last)
                    else report_value("m_last_o", exp_beat.last, m_last_o);
                assert (m_addr_o == exp_beat.addr)
                    else report_value("m_addr_o", exp_beat.addr, m_addr_o);
            end
        end
    end

    // Idle run of cs_n_o measured against the gap of the frame that just ended
    always @(posedge clk_i) begin
        if (rstn_i && (&cs_n_o)) begin
            gap_cnt++;
        end else if (rstn_i) begin
            if (gap_cnt > 0) begin
                assert (gap_cnt >= gap_need)
                    else report_value("cs_n_o idle cycles", gap_need, gap_cnt);
                gap_checks++;
            end
            gap_cnt  = 0;
            gap_need = wait_time_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles in test %s", cycle_cnt, test_name));
        end
    end

    always @(negedge clk_i) begin
        if (u_spi_master_top.u_spi_master_sva.fail_cnt != 0) begin
            abort_run("A bound protocol assertion failed");
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h5f5f_ac3a));
        rstn_i      = 1'b0;
        cpol_i      = 1'b0;
        cpha_i      = 1'b0;
        clk_div_i   = 4;
        wait_time_i = 3;
        addr_i      = '0;
        s_valid_i   = 1'b0;
        s_data_i    = '0;
        s_last_i    = 1'b0;
        m_ready_i   = 1'b1;
        test_name   = "reset";

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        assert (!s_ready_o) else report_value("s_ready_o", 0, s_ready_o);
        assert (!m_valid_o) else report_value("m_valid_o", 0, m_valid_o);
        assert (&cs_n_o) else report_value("cs_n_o", (1 << spi_pkg::SLAVE_NUM) - 1, cs_n_o);
        assert (sck_o == cpol_i) else report_value("sck_o", cpol_i, sck_o);
        rstn_i = 1'b1;
        @(negedge clk_i);

        // Every CPOL/CPHA combination to one slave
        test_name = "mode_loopback";
        for (int mode = 0; mode < 4; mode++) begin
            set_config(mode[1], mode[0], 4, 3, 1);
            send_frame(3);
            wait_idle();
        end

        test_name = "addr_last";
        for (int a = 0; a < spi_pkg::SLAVE_NUM; a++) begin
            set_config(1'b0, 1'b1, 6, 2, a);
            send_frame(2);
            wait_idle();
        end

        // Two frames queued back to back
        test_name = "frame_gap";
        set_config(1'b0, 1'b0, 4, MAX_WAIT, 3);
        checks_before = gap_checks;
        send_frame(2);
        send_frame(2);
        wait_idle();
        assert (gap_checks >= checks_before + 2)
            else abort_run("Inter-frame gaps were not seen at cs_n_o");

        test_name      = "back_pressure";
        set_config(1'b0, 1'b1, 4, 2, 2);
        m_ready_i      = 1'b0;
        saw_ready_drop = 1'b0;
        stall_cycles   = 0;
        held_beats     = 0;
        fork
            begin
                send_frame(5);
                send_frame(5);
            end
            begin
                // Both queues filled and the engine parked behind them
                while ((expect_q.size() < STALL_BEATS) && (stall_cycles < STALL_LIMIT)) begin
                    @(negedge clk_i);
                    stall_cycles++;
                end
                repeat (STALL_HOLD) @(negedge clk_i);
                held_beats     = expect_q.size();
                saw_ready_drop = !s_ready_o;
                m_ready_i      = 1'b1;
            end
        join
        assert (held_beats == STALL_BEATS)
            else report_value("beats taken while stalled", STALL_BEATS, held_beats);
        assert (saw_ready_drop) else abort_run("s_ready_o never dropped under back-pressure");
        wait_idle();

        test_name = "divider_change";
        set_config(1'b1, 1'b0, 2, 4, 0);
        send_frame(3);
        wait_idle();
        set_config(1'b1, 1'b0, MAX_DIV, 4, 0);
        send_frame(3);
        wait_idle();

        if ((u_spi_master_top.u_spi_master_sva.fail_cnt == 0) && (expect_q.size() == 0)) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Bound assertions failed or received beats are missing");
        end
    end

endmodule

// File: src.f
spi_pkg.sv
stream_fifo.sv
spi_clk_gen.sv
spi_shift_engine.sv
spi_master_top.sv
spi_master_sva.sv
tb_spi_master.sv
